// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_core -f filelist.f -o tb_core
	./obj_dir/tb_core

clean:
	rm -rf obj_dir

// ==== core_top.sv ====
module core_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   imem_req,
    output logic [29:0]            imem_addr,
    input  logic                   imem_ack,
    input  logic [31:0]            imem_rdata,
    output pipe_types_pkg::retire_t retire
);

    import pipe_types_pkg::*;

    fetch_pkt_t  fetch_pkt;
    decoded_t    decoded;
    retire_t     ex_retire;
    correction_t correction;
    logic        stall;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .correction (correction),
        .fetch_pkt  (fetch_pkt),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata)
    );

    decode_stage decode_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pkt  (fetch_pkt),
        .correction (correction),
        .ex_retire  (ex_retire),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .stall      (stall),
        .decoded    (decoded)
    );

    execute_stage execute_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .decoded    (decoded),
        .retire     (ex_retire),
        .correction (correction)
    );

    result_stage result_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire_in (ex_retire),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .retire    (retire)
    );

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pipe_types_pkg::fetch_pkt_t  fetch_pkt,
    input  pipe_types_pkg::correction_t correction,
    input  pipe_types_pkg::retire_t     ex_retire,
    output logic [4:0]                 rs1_idx,
    output logic [4:0]                 rs2_idx,
    input  logic [31:0]                rs1_data,
    input  logic [31:0]                rs2_data,
    output logic                       stall,
    output pipe_types_pkg::decoded_t    decoded
);

    import riscv_isa_pkg::*;
    import pipe_types_pkg::*;

    logic [15:0] c;
    logic [11:0] c_imm;
    logic [11:0] cj_off;
    logic [20:0] j_off;
    logic [31:0] inst;
    opcode_e     opc;
    decoded_t    dec_d;
    logic        writes;
    logic        use_imm;
    logic        dep_ex;
    logic        dep_res;

    // expand the supported compressed forms to their 32-bit equivalents
    always_comb begin
        c      = fetch_pkt.inst[15:0];
        c_imm  = {{7{c[12]}}, c[6:2]};
        // c.j offset bits 11,10,9:8,7,6,5,4,3:1
        cj_off = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        j_off  = {{9{cj_off[11]}}, cj_off};
        if (!fetch_pkt.compressed) begin
            inst = fetch_pkt.inst;
        end else begin
            case ({c[15:13], c[1:0]})
                // c.li -> addi rd, x0, imm
                {c_f3_li, c_q1}:
                    inst = {c_imm, 5'd0, 3'b000, c[11:7], opc_op_imm};
                // c.addi -> addi rd, rd, imm
                {c_f3_addi, c_q1}:
                    inst = {c_imm, c[11:7], 3'b000, c[11:7], opc_op_imm};
                // c.j -> jal x0, offset
                {c_f3_j, c_q1}:
                    inst = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd0, opc_jal};
                // c.mv uses x0 as rs1, c.add uses rd
                {c_f3_mv_add, c_q2}:
                    inst = {7'd0, c[6:2], (c[12] ? c[11:7] : 5'd0), 3'b000, c[11:7], opc_op};
                default:
                    inst = nop_inst;
            endcase
        end
    end

    // field decode, unused sources stay at x0
    always_comb begin
        opc              = opcode_e'(inst[6:0]);
        rs1_idx          = 5'd0;
        rs2_idx          = 5'd0;
        writes           = 1'b0;
        use_imm          = 1'b0;
        dec_d.valid      = fetch_pkt.valid;
        dec_d.pc         = fetch_pkt.pc;
        dec_d.compressed = fetch_pkt.compressed;
        dec_d.rd         = inst[11:7];
        dec_d.alu_op     = alu_add;
        dec_d.imm        = 32'd0;
        dec_d.rs1_val    = 32'd0;
        dec_d.rs2_val    = 32'd0;
        case (opc)
            opc_op: begin
                rs1_idx      = inst[19:15];
                rs2_idx      = inst[24:20];
                writes       = 1'b1;
                dec_d.alu_op = (inst[31:25] == f7_sub) ? alu_sub : alu_add;
            end
            opc_op_imm: begin
                rs1_idx   = inst[19:15];
                writes    = 1'b1;
                use_imm   = 1'b1;
                dec_d.imm = {{20{inst[31]}}, inst[31:20]};
            end
            opc_lui: begin
                writes       = 1'b1;
                use_imm      = 1'b1;
                dec_d.alu_op = alu_pass_b;
                dec_d.imm    = {inst[31:12], 12'd0};
            end
            opc_branch: begin
                rs1_idx      = inst[19:15];
                rs2_idx      = inst[24:20];
                dec_d.alu_op = (inst[14:12] == f3_bne) ? alu_branch_ne : alu_branch_eq;
                dec_d.imm    = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            opc_jal: begin
                writes       = 1'b1;
                dec_d.alu_op = alu_jump_link;
                dec_d.imm    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: ;
        endcase
        dec_d.writes_rd = writes && (dec_d.rd != 5'd0);
    end

    // x0 never matches, writes_rd already excludes it
    assign dep_ex  = decoded.valid && decoded.writes_rd &&
                     (decoded.rd == rs1_idx || decoded.rd == rs2_idx);
    // result stage writes at the end of this cycle, read would be stale
    assign dep_res = ex_retire.valid && ex_retire.writes_rd &&
                     (ex_retire.rd == rs1_idx || ex_retire.rd == rs2_idx);
    assign stall   = fetch_pkt.valid && (dep_ex || dep_res);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded         <= dec_d;
            decoded.rs1_val <= rs1_data;
            decoded.rs2_val <= use_imm ? dec_d.imm : rs2_data;
            // bubble into execute
            if (stall || correction.valid) begin
                decoded.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pipe_types_pkg::decoded_t     decoded,
    output pipe_types_pkg::retire_t      retire,
    output pipe_types_pkg::correction_t  correction
);

    import riscv_isa_pkg::*;

    logic [31:0] result;
    logic [31:0] link;
    logic        taken;

    // return address past a 16 or 32-bit jal
    assign link = decoded.pc + (decoded.compressed ? 32'd2 : 32'd4);

    always_comb begin
        result = decoded.rs1_val + decoded.rs2_val;
        taken  = 1'b0;
        case (decoded.alu_op)
            alu_add: ;
            alu_sub: result = decoded.rs1_val - decoded.rs2_val;
            // lui
            alu_pass_b: result = decoded.rs2_val;
            alu_branch_eq: taken = (decoded.rs1_val == decoded.rs2_val);
            alu_branch_ne: taken = (decoded.rs1_val != decoded.rs2_val);
            alu_jump_link: begin
                result = link;
                taken  = 1'b1;
            end
            default: ;
        endcase
    end

    // redirect while the branch sits in execute, younger slots clear on this edge
    assign correction.valid  = decoded.valid && taken;
    assign correction.target = decoded.pc + decoded.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire.valid <= 1'b0;
        end else begin
            retire <= '{valid: decoded.valid, pc: decoded.pc, rd: decoded.rd,
                        data: result, writes_rd: decoded.writes_rd};
        end
    end

endmodule

// ==== fetch_stage.sv ====
module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  pipe_types_pkg::correction_t correction,
    output pipe_types_pkg::fetch_pkt_t  fetch_pkt,
    output logic                       imem_req,
    output logic [29:0]                imem_addr,
    input  logic                       imem_ack,
    input  logic [31:0]                imem_rdata
);

    import riscv_isa_pkg::*;

    logic [31:0] pc_r;
    logic [31:0] pc_d;
    logic [31:0] pc_step;
    logic        inst_ready;
    logic        inst_compressed;
    logic [31:0] inst_aligned;

    // a correction also drops whatever the realigner has in flight
    realigner realigner_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc_r),
        .flush      (correction.valid),
        .ready      (inst_ready),
        .compressed (inst_compressed),
        .inst       (inst_aligned),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata)
    );

    assign pc_step = pc_r + (inst_compressed ? 32'd2 : 32'd4);

    // correction wins, then sequential step
    always_comb begin
        if (correction.valid) begin
            pc_d = correction.target;
        end else if (inst_ready && !stall) begin
            pc_d = pc_step;
        end else begin
            pc_d = pc_r;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_r            <= RESET_PC;
            fetch_pkt.valid <= 1'b0;
        end else begin
            pc_r <= pc_d;
            if (correction.valid || (!stall && !inst_ready)) begin
                // younger slot or empty cycle becomes a bubble
                fetch_pkt <= '{valid: 1'b0, pc: pc_r, inst: nop_inst, compressed: 1'b0};
            end else if (!stall) begin
                fetch_pkt <= '{valid: 1'b1, pc: pc_r, inst: inst_aligned,
                               compressed: inst_compressed};
            end
        end
    end

    // corrections and steps keep halfword alignment
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_r[0] == 1'b0);

endmodule

// ==== filelist.f ====
riscv_isa_pkg.sv
pipe_types_pkg.sv
realigner.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
tb_imem_model.sv
tb_core.sv

// ==== pipe_types_pkg.sv ====
package pipe_types_pkg;

    // fetch to decode, inst is raw, compressed ones sit in the low half
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        compressed;
    } fetch_pkt_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        riscv_isa_pkg::alu_op_e alu_op;
        logic [4:0]            rd;
        logic [31:0]           rs1_val;
        // operand b, carries the immediate for addi and lui
        logic [31:0]           rs2_val;
        // branch or jump offset
        logic [31:0]           imm;
        logic                  writes_rd;
        logic                  compressed;
    } decoded_t;

    // execute to result stage and retire report
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        writes_rd;
    } retire_t;

    // taken branch or jump back to fetch
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } correction_t;

endpackage

// ==== realigner.sv ====
module realigner (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pc,
    input  logic        flush,
    output logic        ready,
    output logic        compressed,
    output logic [31:0] inst,
    output logic        imem_req,
    output logic [29:0] imem_addr,
    input  logic        imem_ack,
    input  logic [31:0] imem_rdata
);

    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_release
    } state_e;

    state_e      state;
    // last word read and its word address
    logic [31:0] buf_word;
    logic [29:0] buf_addr;
    logic        buf_valid;
    // upper half of the word before buf_addr
    logic [15:0] carry_half;
    logic        carry_valid;
    // response of a flushed request is thrown away
    logic        discard;
    logic        hit_cur;
    logic        hit_prev;
    logic [15:0] half_lo;
    logic [15:0] half_hi;
    logic [29:0] need_addr;

    // pc word is the buffered one
    assign hit_cur  = buf_valid && (buf_addr == pc[31:2]);
    // pc at +2 of the previous word, low half kept in carry
    assign hit_prev = buf_valid && carry_valid && pc[1] && (buf_addr == pc[31:2] + 30'd1);

    assign half_lo = hit_cur ? (pc[1] ? buf_word[31:16] : buf_word[15:0]) : carry_half;
    // upper half comes from the next word when pc sits at +2
    assign half_hi = pc[1] ? buf_word[15:0] : buf_word[31:16];

    assign compressed = (half_lo[1:0] != 2'b11);
    // 32-bit at +2 of the buffered word needs the next word first
    assign ready      = hit_prev || (hit_cur && (compressed || !pc[1]));
    assign inst       = compressed ? {16'h0000, half_lo} : {half_hi, half_lo};

    assign need_addr = (hit_cur && pc[1]) ? pc[31:2] + 30'd1 : pc[31:2];

    // four-phase req/ack towards instruction memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= idle;
            imem_req    <= 1'b0;
            discard     <= 1'b0;
            buf_valid   <= 1'b0;
            carry_valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // ack is already low here
                    if (!ready && !flush) begin
                        imem_req  <= 1'b1;
                        imem_addr <= need_addr;
                        discard   <= 1'b0;
                        state     <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (flush) begin
                        discard <= 1'b1;
                    end
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        state    <= wait_release;
                        if (!flush && !discard) begin
                            buf_word    <= imem_rdata;
                            buf_addr    <= imem_addr;
                            buf_valid   <= 1'b1;
                            // old upper half still useful only for the next word
                            carry_half  <= buf_word[31:16];
                            carry_valid <= buf_valid && (imem_addr == buf_addr + 30'd1);
                        end
                    end
                end
                wait_release: begin
                    if (!imem_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // memory still holds ack from the last transfer
    req_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(imem_req) |-> !imem_ack);

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && $past(imem_req) |-> $stable(imem_addr));

endmodule

// ==== result_stage.sv ====
module result_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_types_pkg::retire_t retire_in,
    input  logic [4:0]             rs1_idx,
    input  logic [4:0]             rs2_idx,
    output logic [31:0]            rs1_data,
    output logic [31:0]            rs2_data,
    output pipe_types_pkg::retire_t retire
);

    // x1..x31, x0 is hardwired
    logic [31:0] regs [1:31];

    // read ports are combinational, no bypass of the write in flight
    assign rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (retire_in.valid && retire_in.writes_rd) begin
            regs[retire_in.rd] <= retire_in.data;
        end
    end

    // retire report one cycle behind the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire.valid <= 1'b0;
        end else begin
            retire <= retire_in;
        end
    end

    // decode clears writes_rd for rd x0
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire_in.valid && retire_in.writes_rd |-> retire_in.rd != 5'd0);

endmodule

// ==== riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    // major opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    // execute operations
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_pass_b,
        alu_branch_eq,
        alu_branch_ne,
        alu_jump_link
    } alu_op_e;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // funct fields of the 32-bit forms
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [6:0] f7_sub = 7'b0100000;

    // compressed quadrants and funct3 values
    localparam logic [1:0] c_q1        = 2'b01;
    localparam logic [1:0] c_q2        = 2'b10;
    localparam logic [2:0] c_f3_addi   = 3'b000;
    localparam logic [2:0] c_f3_li     = 3'b010;
    localparam logic [2:0] c_f3_j      = 3'b101;
    localparam logic [2:0] c_f3_mv_add = 3'b100;

endpackage

// ==== tb_core.sv ====
module tb_core;

    import pipe_types_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int MAX_ACK = 4;
    localparam int LOOP_REPS = 3;

    logic        clk;
    logic        rst_n;
    logic        imem_req;
    logic [29:0] imem_addr;
    logic        imem_ack;
    logic [31:0] imem_rdata;
    retire_t     retire;

    // expected retire sequence from the reference model
    logic [31:0] exp_pc [0:63];
    logic [4:0]  exp_rd [0:63];
    logic [31:0] exp_data [0:63];
    logic        exp_wr [0:63];
    int          n_exp;
    int          n_pass;
    int          ret_idx;
    int          cyc;

    core_top #(
        .RESET_PC (RESET_PC)
    ) core_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .retire     (retire)
    );

    tb_imem_model #(
        .MAX_ACK (MAX_ACK)
    ) imem_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (imem_req),
        .addr  (imem_addr),
        .ack   (imem_ack),
        .rdata (imem_rdata)
    );

    always #4 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] o);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] o);
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
    endfunction

    // c.li and c.addi share the ci layout
    function automatic logic [15:0] enc_ci(logic [2:0] f3, logic [4:0] rd, logic [5:0] imm);
        return {f3, imm[5], rd, imm[4:0], 2'b01};
    endfunction

    // bit 12 picks c.add over c.mv
    function automatic logic [15:0] enc_cr(logic b12, logic [4:0] rd, logic [4:0] rs2);
        return {3'b100, b12, rd, rs2, 2'b10};
    endfunction

    function automatic logic [15:0] enc_cj(logic [11:0] o);
        return {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    endfunction

    task automatic place16(input logic [31:0] a, input logic [15:0] h);
        imem_inst.mem[a[7:2]][a[1]*16 +: 16] = h;
    endtask

    task automatic place32(input logic [31:0] a, input logic [31:0] w);
        place16(a, w[15:0]);
        place16(a + 32'd2, w[31:16]);
    endtask

    function automatic logic [15:0] half_at(logic [31:0] a);
        return imem_inst.mem[a[7:2]][a[1]*16 +: 16];
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    // architectural model walking the same memory image
    task automatic build_expected();
        logic [31:0] r [0:31];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] i;
        logic [31:0] imm;
        logic [31:0] val;
        logic [15:0] h;
        logic [4:0]  rd;
        logic        wr;
        int          loops;
        for (int k = 0; k < 32; k++) begin
            r[k] = 32'd0;
        end
        pc = RESET_PC;
        loops = 0;
        n_exp = 0;
        n_pass = 0;
        while (loops < LOOP_REPS + 2 && n_exp < 64) begin
            h = half_at(pc);
            wr = 1'b0;
            val = 32'd0;
            rd = h[11:7];
            if (h[1:0] != 2'b11) begin
                nxt = pc + 32'd2;
                imm = {{26{h[12]}}, h[12], h[6:2]};
                if (h[1:0] == 2'b01 && h[15:13] == 3'b010) begin
                    wr = 1'b1;
                    val = imm;
                end else if (h[1:0] == 2'b01 && h[15:13] == 3'b000) begin
                    wr = 1'b1;
                    val = r[rd] + imm;
                end else if (h[1:0] == 2'b01 && h[15:13] == 3'b101) begin
                    nxt = pc + {{20{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11],
                                h[5:3], 1'b0};
                end else if (h[1:0] == 2'b10 && h[15:13] == 3'b100) begin
                    wr = 1'b1;
                    val = h[12] ? r[rd] + r[h[6:2]] : r[h[6:2]];
                end
            end else begin
                i = {half_at(pc + 32'd2), h};
                nxt = pc + 32'd4;
                case (i[6:0])
                    7'h33: begin
                        wr = 1'b1;
                        val = i[30] ? r[i[19:15]] - r[i[24:20]] : r[i[19:15]] + r[i[24:20]];
                    end
                    7'h13: begin
                        wr = 1'b1;
                        val = r[i[19:15]] + {{20{i[31]}}, i[31:20]};
                    end
                    7'h37: begin
                        wr = 1'b1;
                        val = {i[31:12], 12'd0};
                    end
                    7'h63: begin
                        imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
                        // funct3 bit 12 separates bne from beq
                        if ((r[i[19:15]] == r[i[24:20]]) != i[12]) begin
                            nxt = pc + imm;
                        end
                    end
                    7'h6f: begin
                        wr = 1'b1;
                        val = pc + 32'd4;
                        nxt = pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
                    end
                    default: ;
                endcase
            end
            wr = wr && (rd != 5'd0);
            exp_pc[n_exp] = pc;
            exp_rd[n_exp] = rd;
            exp_data[n_exp] = val;
            exp_wr[n_exp] = wr;
            n_exp++;
            if (wr) begin
                r[rd] = val;
            end
            // a jump to itself marks the final loop
            if (nxt == pc) begin
                loops++;
                if (loops == LOOP_REPS) begin
                    n_pass = n_exp;
                end
            end
            pc = nxt;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        // unused words vary with their address and hold c.nop in the low half
        for (int k = 0; k < 64; k++) begin
            imem_inst.mem[k] = {k[15:0], 16'h0001};
        end
        place16(32'h00, enc_ci(3'b010, 5'd1, 6'd5));
        // 32-bit at a halfword offset spanning words 0 and 1
        place32(32'h02, enc_i(12'd3, 5'd1, 5'd2));
        place16(32'h06, enc_cr(1'b1, 5'd2, 5'd1));
        place16(32'h08, enc_cr(1'b0, 5'd3, 5'd2));
        place16(32'h0A, enc_ci(3'b000, 5'd3, 6'h3f));
        place32(32'h0C, enc_r(7'h20, 5'd1, 5'd3, 5'd4));
        place32(32'h10, {20'h12345, 5'd5, 7'h37});
        place32(32'h14, enc_r(7'h00, 5'd4, 5'd5, 5'd6));
        place16(32'h18, enc_ci(3'b010, 5'd7, 6'd6));
        // beq falls through and bne skips to 0x28
        place32(32'h1A, enc_b(3'b000, 5'd4, 5'd7, 13'd8));
        place32(32'h1E, enc_b(3'b001, 5'd4, 5'd7, 13'd10));
        place16(32'h22, enc_ci(3'b010, 5'd8, 6'd1));
        place32(32'h24, enc_i(12'd1, 5'd8, 5'd8));
        // jal over two instructions with link into x1
        place32(32'h28, enc_j(5'd1, 21'd10));
        place16(32'h2C, enc_ci(3'b010, 5'd9, 6'd9));
        place32(32'h2E, enc_i(12'd1, 5'd0, 5'd9));
        place16(32'h32, enc_cr(1'b0, 5'd10, 5'd1));
        place16(32'h34, enc_ci(3'b000, 5'd10, 6'd2));
        place16(32'h36, enc_cj(12'd0));
        build_expected();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

    // watchdog scaled by the retire count and the ack delay
    initial begin
        #1;
        repeat (n_pass * (MAX_ACK + 4) * 4 + 20) @(posedge clk);
        $display("timeout: retirement stopped at %0d of %0d instructions", ret_idx, n_pass);
        stop_run();
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n && retire.valid) begin
            ret_idx <= ret_idx + 1;
        end
        if (rst_n && ret_idx >= n_pass && n_pass > 0) begin
            $display("test passed");
            $finish;
        end
    end

    initial begin
        cyc = 0;
        ret_idx = 0;
    end

    // quiet outputs while reset holds
    reset_quiet: assert property (@(posedge clk) !rst_n && cyc > 0 |->
        !imem_req && !retire.valid)
        else begin
            $display("[ERROR] %0t imem_req/retire.valid expected 0/0 got %b/%b",
                     $time, imem_req, retire.valid);
            stop_run();
        end

    ret_pc: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_exp |-> retire.pc == exp_pc[ret_idx])
        else begin
            $display("[ERROR] %0t retire.pc expected %h got %h",
                     $time, exp_pc[ret_idx], retire.pc);
            stop_run();
        end

    ret_wr: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_exp |-> retire.writes_rd == exp_wr[ret_idx])
        else begin
            $display("[ERROR] %0t retire.writes_rd expected %b got %b",
                     $time, exp_wr[ret_idx], retire.writes_rd);
            stop_run();
        end

    ret_rd: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_exp && exp_wr[ret_idx] |-> retire.rd == exp_rd[ret_idx])
        else begin
            $display("[ERROR] %0t retire.rd expected %0d got %0d",
                     $time, exp_rd[ret_idx], retire.rd);
            stop_run();
        end

    ret_data: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_exp && exp_wr[ret_idx] |->
        retire.data == exp_data[ret_idx])
        else begin
            $display("[ERROR] %0t retire.data expected %h got %h",
                     $time, exp_data[ret_idx], retire.data);
            stop_run();
        end

    // four-phase rules seen on the memory side
    req_release: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && imem_ack |=> !imem_req)
        else begin
            $display("request still high one cycle after ack was seen");
            stop_run();
        end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req)
        else begin
            $display("request dropped before ack was seen");
            stop_run();
        end

endmodule

// ==== tb_imem_model.sv ====
module tb_imem_model #(
    parameter int MAX_ACK = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic [29:0] addr,
    output logic        ack,
    output logic [31:0] rdata
);

    // program words loaded by the testbench top
    logic [31:0] mem [0:63];
    integer      seed = 32'h60cc;
    int          cnt;
    logic        armed;

    // four-phase slave with a random wait before each ack
    always @(posedge clk) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            rdata <= 32'd0;
            armed <= 1'b0;
            cnt   <= 0;
        end else if (req && !ack) begin
            if (!armed) begin
                armed <= 1'b1;
                cnt   <= int'($unsigned($random(seed)) % MAX_ACK);
            end else if (cnt == 0) begin
                ack   <= 1'b1;
                rdata <= mem[addr[5:0]];
                armed <= 1'b0;
            end else begin
                cnt <= cnt - 1;
            end
        end else if (!req && ack) begin
            // release once req has dropped
            ack <= 1'b0;
        end
    end

endmodule
